//--- logic/usb_std_pkg.sv
package usb_std_pkg;

  // Request opcodes produced by the EP0 decoder
  // Encoding follows the classic control pipe layout
  typedef enum logic [2:0] {
    REQ_NONE      = 3'd0,
    GET_DEV_DESC  = 3'd1,
    SET_ADDRESS   = 3'd2,
    GET_CONF_DESC = 3'd3,
    SET_CONFIG    = 3'd4,
    GET_STRING    = 3'd5
  } ep0_req_e;

  // Standard bRequest codes handled by EP0
  localparam logic [7:0] BREQ_SET_ADDRESS    = 8'd5;
  localparam logic [7:0] BREQ_GET_DESCRIPTOR = 8'd6;
  localparam logic [7:0] BREQ_SET_CONFIG     = 8'd9;

  // Descriptor types, found in the high byte of wValue
  localparam logic [7:0] DTYPE_DEVICE = 8'd1;
  localparam logic [7:0] DTYPE_CONFIG = 8'd2;
  localparam logic [7:0] DTYPE_STRING = 8'd3;

  // bmRequestType fields
  // Type lives in bits 6:5, recipient in bits 4:0
  localparam logic [1:0] RTYPE_STANDARD = 2'b00;
  localparam logic [4:0] RCPT_DEVICE    = 5'b00000;

endpackage

//--- logic/usb_desc_pkg.sv
package usb_desc_pkg;

  // Device identity
  localparam logic [15:0] VENDOR_ID  = 16'hFACE;
  localparam logic [15:0] PRODUCT_ID = 16'h0BDE;

  // Four-character ASCII strings, first character in the top byte
  localparam logic [31:0] MANUFACTURER_STR = "OPEN";
  localparam logic [31:0] PRODUCT_STR      = "CTL0";
  localparam logic [31:0] SERIAL_STR       = "0001";

  // Descriptor lengths in bytes
  localparam int DEVICE_DESC_LEN = 18;
  localparam int CONFIG_DESC_LEN = 18;
  localparam int STR0_DESC_LEN   = 4;
  localparam int STRN_DESC_LEN   = 10;

  // ROM geometry
  localparam int DESC_SIZE   = 70;
  localparam int DESC_ADDR_W = 7;

  // Byte offset of each descriptor inside the ROM
  localparam int DESC_CONFIG_START = DEVICE_DESC_LEN;
  localparam int DESC_STR0_START   = DESC_CONFIG_START + CONFIG_DESC_LEN;
  localparam int DESC_STR1_START   = DESC_STR0_START + STR0_DESC_LEN;
  localparam int DESC_STR2_START   = DESC_STR1_START + STRN_DESC_LEN;
  localparam int DESC_STR3_START   = DESC_STR2_START + STRN_DESC_LEN;

  // String descriptor from four ASCII chars
  // Byte 0 ends up in the low bits, each char widened to UTF-16LE
  function automatic logic [79:0] str_desc(input logic [31:0] s);
    str_desc = {8'h00, s[7:0], 8'h00, s[15:8], 8'h00, s[23:16], 8'h00, s[31:24],
                8'h03, 8'(STRN_DESC_LEN)};
  endfunction

  // Full-speed device descriptor, byte 0 in the low bits
  localparam logic [143:0] DEVICE_DESC = {
    8'h01, 8'h03, 8'h02, 8'h01,
    16'h0000, PRODUCT_ID, VENDOR_ID,
    8'h40, 8'h00, 8'h00, 8'hFF,
    16'h0110, 8'h01, 8'(DEVICE_DESC_LEN)
  };

  // Configuration plus one interface with no endpoints
  localparam logic [143:0] CONFIG_DESC = {
    8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h04, 8'h09,
    8'h32, 8'hC0, 8'h00, 8'h01, 8'h01,
    16'(CONFIG_DESC_LEN), 8'h02, 8'h09
  };

  // Language ID list with US English only
  localparam logic [31:0] STR0_DESC = {16'h0409, 8'h03, 8'(STR0_DESC_LEN)};

  // Complete ROM image, lowest offset in the low bits
  localparam logic [DESC_SIZE*8-1:0] USB_DESC = {
    str_desc(SERIAL_STR),
    str_desc(PRODUCT_STR),
    str_desc(MANUFACTURER_STR),
    STR0_DESC,
    CONFIG_DESC,
    DEVICE_DESC
  };

endpackage

//--- logic/ep0_request_decoder.sv
`timescale 1ns/1ns

module ep0_request_decoder (
  input  logic [7:0]           req_type_i,
  input  logic [7:0]           req_request_i,
  input  logic [15:0]          req_value_i,
  output usb_std_pkg::ep0_req_e req_op_o,
  output logic [1:0]           str_index_o
);

  import usb_std_pkg::*;

  logic is_std_dev;

  // Only standard requests aimed at the device are handled here
  assign is_std_dev = (req_type_i[6:5] == RTYPE_STANDARD) &&
                      (req_type_i[4:0] == RCPT_DEVICE);

  // Map bRequest and descriptor type onto an opcode
  always_comb begin
    req_op_o = REQ_NONE;
    if (is_std_dev) begin
      case (req_request_i)
        BREQ_SET_ADDRESS: req_op_o = SET_ADDRESS;
        BREQ_SET_CONFIG:  req_op_o = SET_CONFIG;
        BREQ_GET_DESCRIPTOR: begin
          case (req_value_i[15:8])
            DTYPE_DEVICE: req_op_o = GET_DEV_DESC;
            DTYPE_CONFIG: req_op_o = GET_CONF_DESC;
            DTYPE_STRING: req_op_o = GET_STRING;
            default:      req_op_o = REQ_NONE;
          endcase
        end
        default: req_op_o = REQ_NONE;
      endcase
    end
  end

  // String index from wValue low byte
  // Anything past the serial string falls back to the language list
  always_comb begin
    if (req_value_i[7:0] > 8'd3) begin
      str_index_o = 2'd0;
    end else begin
      str_index_o = req_value_i[1:0];
    end
  end

endmodule

//--- logic/desc_streamer.sv
`timescale 1ns/1ns

module desc_streamer (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  select_i,
  input  logic                  start_i,
  input  logic                  stop_i,
  input  usb_std_pkg::ep0_req_e req_op_i,
  input  logic [1:0]            str_index_i,
  input  logic                  m_tready_i,
  output logic                  m_tvalid_o,
  output logic                  m_tlast_o,
  output logic [7:0]            m_tdata_o,
  output logic                  done_o
);

  import usb_std_pkg::*;
  import usb_desc_pkg::*;

  typedef enum logic {
    IDLE,
    STREAM
  } stream_state_e;

  stream_state_e state_q;

  logic [7:0]             rom_data [DESC_SIZE];
  logic                   rom_last [DESC_SIZE];
  logic [DESC_ADDR_W-1:0] addr_q;
  logic [DESC_ADDR_W-1:0] start_addr;
  logic                   is_get;
  logic                   launch;
  logic                   handshake;

  // ROM bytes and end-of-descriptor flags
  for (genvar i = 0; i < DESC_SIZE; i++) begin : g_rom
    assign rom_data[i] = USB_DESC[i*8 +: 8];
    assign rom_last[i] = (i == DESC_STR0_START - 1) || (i == DESC_CONFIG_START - 1) ||
                         (i == DESC_STR1_START - 1) || (i == DESC_STR2_START - 1) ||
                         (i == DESC_STR3_START - 1) || (i == DESC_SIZE - 1);
  end

  assign is_get = (req_op_i == GET_DEV_DESC) || (req_op_i == GET_CONF_DESC) ||
                  (req_op_i == GET_STRING);

  // New stream only from idle, starts while busy are dropped
  assign launch    = select_i && start_i && is_get && (state_q == IDLE);
  assign handshake = m_tvalid_o && m_tready_i;

  // First byte of the requested descriptor
  always_comb begin
    case (req_op_i)
      GET_CONF_DESC: start_addr = DESC_ADDR_W'(DESC_CONFIG_START);
      GET_STRING: begin
        case (str_index_i)
          2'd1:    start_addr = DESC_ADDR_W'(DESC_STR1_START);
          2'd2:    start_addr = DESC_ADDR_W'(DESC_STR2_START);
          2'd3:    start_addr = DESC_ADDR_W'(DESC_STR3_START);
          default: start_addr = DESC_ADDR_W'(DESC_STR0_START);
        endcase
      end
      default: start_addr = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else if (!select_i) begin
      // Host moved on, abandon whatever was in flight
      state_q <= IDLE;
    end else if (state_q == IDLE) begin
      if (launch) begin
        state_q <= STREAM;
        addr_q  <= start_addr;
      end
    end else if (handshake) begin
      addr_q <= addr_q + 1'b1;
      if (m_tlast_o || stop_i) begin
        state_q <= IDLE;
      end
    end
  end

  // Data and last follow the address, so they hold under back-pressure
  assign m_tvalid_o = (state_q == STREAM);
  assign m_tdata_o  = rom_data[addr_q];
  assign m_tlast_o  = rom_last[addr_q];

  // End of stream, either natural or by stop
  assign done_o = select_i && handshake && (m_tlast_o || stop_i);

endmodule

//--- logic/device_state.sv
`timescale 1ns/1ns

module device_state (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  select_i,
  input  logic                  start_i,
  input  usb_std_pkg::ep0_req_e req_op_i,
  input  logic [15:0]           req_value_i,
  output logic [6:0]            usb_addr_o,
  output logic [7:0]            usb_conf_o,
  output logic                  configured_o,
  output logic                  accepted_o
);

  import usb_std_pkg::*;

  logic set_addr;
  logic set_conf;

  assign set_addr = select_i && start_i && (req_op_i == SET_ADDRESS);
  assign set_conf = select_i && start_i && (req_op_i == SET_CONFIG);

  always_ff @(posedge clock) begin
    if (reset) begin
      usb_addr_o   <= '0;
      usb_conf_o   <= '0;
      configured_o <= 1'b0;
    end else if (set_addr) begin
      usb_addr_o <= req_value_i[6:0];
    end else if (set_conf) begin
      usb_conf_o <= req_value_i[7:0];
      // Sticky once set, even for configuration value zero
      configured_o <= 1'b1;
    end
  end

  // Store strobe, the status block registers it into ack
  assign accepted_o = set_addr || set_conf;

endmodule

//--- logic/ep0_status.sv
`timescale 1ns/1ns

module ep0_status (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  select_i,
  input  logic                  start_i,
  input  usb_std_pkg::ep0_req_e req_op_i,
  input  logic                  stream_done_i,
  input  logic                  set_accepted_i,
  output logic                  error_o,
  output logic                  ack_o
);

  import usb_std_pkg::*;

  logic bad_req;

  // Unknown or unsupported request while this endpoint is selected
  assign bad_req = select_i && start_i && (req_op_i == REQ_NONE);

  // Error level holds until the transfer is released
  always_ff @(posedge clock) begin
    if (reset) begin
      error_o <= 1'b0;
    end else if (bad_req) begin
      error_o <= 1'b1;
    end else if (!select_i) begin
      error_o <= 1'b0;
    end
  end

  // Either completion source gives a single ack pulse
  always_ff @(posedge clock) begin
    if (reset) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= stream_done_i || set_accepted_i;
    end
  end

endmodule

//--- logic/ctl_pipe0_top.sv
`timescale 1ns/1ns

module ctl_pipe0_top (
  input  logic        clock,
  input  logic        reset,
  input  logic        select_i,
  input  logic        start_i,
  input  logic        stop_i,
  input  logic [7:0]  req_type_i,
  input  logic [7:0]  req_request_i,
  input  logic [15:0] req_value_i,
  input  logic [15:0] req_index_i,
  input  logic [15:0] req_length_i,
  input  logic        m_tready_i,
  output logic        m_tvalid_o,
  output logic        m_tlast_o,
  output logic [7:0]  m_tdata_o,
  output logic        error_o,
  output logic        ack_o,
  output logic        configured_o,
  output logic [6:0]  usb_addr_o,
  output logic [7:0]  usb_conf_o
);

  import usb_std_pkg::*;

  // wIndex and wLength belong to the transfer interface
  // Reply truncation is done upstream, so both stay unused here
  ep0_req_e   req_op;
  logic [1:0] str_index;
  logic       stream_done;
  logic       set_accepted;

  // Combinational request classification
  ep0_request_decoder u_decoder (
    .req_type_i    (req_type_i),
    .req_request_i (req_request_i),
    .req_value_i   (req_value_i),
    .req_op_o      (req_op),
    .str_index_o   (str_index)
  );

  // GET_DESCRIPTOR byte stream
  desc_streamer u_streamer (
    .clock       (clock),
    .reset       (reset),
    .select_i    (select_i),
    .start_i     (start_i),
    .stop_i      (stop_i),
    .req_op_i    (req_op),
    .str_index_i (str_index),
    .m_tready_i  (m_tready_i),
    .m_tvalid_o  (m_tvalid_o),
    .m_tlast_o   (m_tlast_o),
    .m_tdata_o   (m_tdata_o),
    .done_o      (stream_done)
  );

  // Address and configuration registers
  device_state u_dev_state (
    .clock        (clock),
    .reset        (reset),
    .select_i     (select_i),
    .start_i      (start_i),
    .req_op_i     (req_op),
    .req_value_i  (req_value_i),
    .usb_addr_o   (usb_addr_o),
    .usb_conf_o   (usb_conf_o),
    .configured_o (configured_o),
    .accepted_o   (set_accepted)
  );

  // Error and acknowledge
  ep0_status u_status (
    .clock          (clock),
    .reset          (reset),
    .select_i       (select_i),
    .start_i        (start_i),
    .req_op_i       (req_op),
    .stream_done_i  (stream_done),
    .set_accepted_i (set_accepted),
    .error_o        (error_o),
    .ack_o          (ack_o)
  );

endmodule

//--- tests/ctl_pipe0_tb.sv
`timescale 1ns/1ns

module ctl_pipe0_tb;

  import usb_std_pkg::*;
  import usb_desc_pkg::*;

  localparam int CLK_PERIOD   = 8;
  // Eight GETs, two SETs, two bad requests, two starts with select low
  localparam int NUM_REQUESTS = 14;

  logic        clock;
  logic        reset;
  logic        select_i;
  logic        start_i;
  logic        stop_i;
  logic [7:0]  req_type_i;
  logic [7:0]  req_request_i;
  logic [15:0] req_value_i;
  logic [15:0] req_index_i;
  logic [15:0] req_length_i;
  logic        m_tready_i;
  logic        m_tvalid_o;
  logic        m_tlast_o;
  logic [7:0]  m_tdata_o;
  logic        error_o;
  logic        ack_o;
  logic        configured_o;
  logic [6:0]  usb_addr_o;
  logic [7:0]  usb_conf_o;

  // Stream expected by the monitor
  ep0_req_e   cur_kind;
  int         cur_idx;
  int         cur_len;
  int         rx_count;
  int         ack_count;
  logic       expect_stream;
  integer     seed;
  // Model of the device registers
  logic [6:0] exp_addr;
  logic [7:0] exp_conf;
  logic       exp_configured;

  ctl_pipe0_top UUT (.*);

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  endtask

  // Descriptor length in bytes
  function automatic int descriptor_length(input ep0_req_e kind, input int idx);
    if (kind == GET_STRING) begin
      return (idx == 0) ? STR0_DESC_LEN : STRN_DESC_LEN;
    end
    return (kind == GET_CONF_DESC) ? CONFIG_DESC_LEN : DEVICE_DESC_LEN;
  endfunction

  // One descriptor byte with multi-byte fields little endian
  function automatic logic [7:0] expected_byte(input ep0_req_e kind, input int idx,
                                               input int pos);
    logic [31:0] str;
    logic [7:0]  b;
    b = 8'h00;
    case (kind)
      GET_DEV_DESC: begin
        // bcdUSB 1.10, vendor class, 64 byte EP0, three strings, one configuration
        case (pos)
          0:  b = 8'(DEVICE_DESC_LEN);
          1:  b = 8'h01;
          2:  b = 8'h10;
          3:  b = 8'h01;
          4:  b = 8'hFF;
          7:  b = 8'h40;
          8:  b = VENDOR_ID[7:0];
          9:  b = VENDOR_ID[15:8];
          10: b = PRODUCT_ID[7:0];
          11: b = PRODUCT_ID[15:8];
          14: b = 8'h01;
          15: b = 8'h02;
          16: b = 8'h03;
          17: b = 8'h01;
          default: b = 8'h00;
        endcase
      end
      GET_CONF_DESC: begin
        // Self powered, 100 mA, then one interface with no endpoints
        case (pos)
          0:  b = 8'h09;
          1:  b = 8'h02;
          2:  b = 8'(CONFIG_DESC_LEN);
          4:  b = 8'h01;
          5:  b = 8'h01;
          7:  b = 8'hC0;
          8:  b = 8'h32;
          9:  b = 8'h09;
          10: b = 8'h04;
          default: b = 8'h00;
        endcase
      end
      default: begin
        str = (idx == 1) ? MANUFACTURER_STR : (idx == 2) ? PRODUCT_STR : SERIAL_STR;
        if (pos == 0) begin
          b = (idx == 0) ? 8'(STR0_DESC_LEN) : 8'(STRN_DESC_LEN);
        end else if (pos == 1) begin
          b = 8'h03;
        end else if (idx == 0) begin
          // Language ID 0x0409
          b = (pos == 2) ? 8'h09 : 8'h04;
        end else if (pos % 2 == 0) begin
          // First character sits in the top byte of the string constant
          b = 8'(str >> (8 * (3 - (pos - 2) / 2)));
        end
      end
    endcase
    return b;
  endfunction

  // Compares every transferred byte at mid cycle
  always @(negedge clock) begin
    if (m_tvalid_o && m_tready_i) begin
      check_value(expect_stream, 1'b1, "byte transferred outside a GET request");
      check_value(m_tdata_o, expected_byte(cur_kind, cur_idx, rx_count),
                  $sformatf("tdata of byte %0d", rx_count));
      check_value(m_tlast_o, rx_count == cur_len - 1,
                  $sformatf("tlast of byte %0d", rx_count));
      rx_count++;
    end
    if (ack_o) begin
      ack_count++;
    end
  end

  task automatic compare_registers();
    check_value(usb_addr_o, exp_addr, "usb_addr_o");
    check_value(usb_conf_o, exp_conf, "usb_conf_o");
    check_value(configured_o, exp_configured, "configured_o");
  endtask

  // GET_DESCRIPTOR with random stalls
  // A stop_at above zero raises stop on that byte
  task automatic get_descriptor(input ep0_req_e kind, input logic [7:0] str_raw,
                                input int stop_at);
    int target;
    int acks;
    cur_kind = kind;
    cur_idx  = (str_raw > 8'd3) ? 0 : int'(str_raw);
    cur_len  = descriptor_length(kind, cur_idx);
    target   = (stop_at > 0) ? stop_at : cur_len;
    rx_count = 0;
    acks     = ack_count;
    expect_stream = 1'b1;
    select_i      = 1'b1;
    start_i       = 1'b1;
    req_type_i    = 8'h80;
    req_request_i = BREQ_GET_DESCRIPTOR;
    case (kind)
      GET_DEV_DESC:  req_value_i = {DTYPE_DEVICE, str_raw};
      GET_CONF_DESC: req_value_i = {DTYPE_CONFIG, str_raw};
      default:       req_value_i = {DTYPE_STRING, str_raw};
    endcase
    @(posedge clock);
    #1;
    start_i = 1'b0;
    check_value(m_tvalid_o, 1'b1, "tvalid one cycle after start");
    while (rx_count < target) begin
      m_tready_i = ($random(seed) & 3) != 0;
      stop_i     = (stop_at > 0) && (rx_count == stop_at - 1);
      @(posedge clock);
      #1;
    end
    // Ready stays high so any byte past the end gets counted
    m_tready_i = 1'b1;
    stop_i     = 1'b0;
    check_value(m_tvalid_o, 1'b0, "tvalid after the final byte");
    repeat (3) @(posedge clock);
    #1;
    check_value(rx_count, target, "bytes in stream");
    check_value(ack_count - acks, 1, "ack pulses after stream");
    expect_stream = 1'b0;
    select_i      = 1'b0;
    @(posedge clock);
    #1;
  endtask

  task automatic set_register(input logic [7:0] breq, input logic [15:0] value);
    select_i      = 1'b1;
    start_i       = 1'b1;
    req_type_i    = 8'h00;
    req_request_i = breq;
    req_value_i   = value;
    if (breq == BREQ_SET_ADDRESS) begin
      exp_addr = value[6:0];
    end else begin
      exp_conf       = value[7:0];
      exp_configured = 1'b1;
    end
    @(posedge clock);
    #1;
    start_i = 1'b0;
    check_value(ack_o, 1'b1, "ack one cycle after SET");
    compare_registers();
    @(posedge clock);
    #1;
    check_value(ack_o, 1'b0, "ack after one cycle");
    select_i = 1'b0;
    @(posedge clock);
    #1;
  endtask

  task automatic send_unsupported(input logic [7:0] rtype, input logic [7:0] breq);
    int acks;
    acks          = ack_count;
    select_i      = 1'b1;
    start_i       = 1'b1;
    req_type_i    = rtype;
    req_request_i = breq;
    req_value_i   = 16'h0100;
    @(posedge clock);
    #1;
    start_i = 1'b0;
    check_value(error_o, 1'b1, "error one cycle after bad request");
    check_value(m_tvalid_o, 1'b0, "tvalid on bad request");
    repeat (2) @(posedge clock);
    #1;
    check_value(error_o, 1'b1, "error held while selected");
    select_i = 1'b0;
    @(posedge clock);
    #1;
    check_value(error_o, 1'b0, "error after select falls");
    check_value(ack_count - acks, 0, "ack pulses on bad request");
  endtask

  initial begin
    #(NUM_REQUESTS * 200 * CLK_PERIOD);
    $display("Timeout: the simulation hung waiting for the DUT");
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

  initial begin
    seed           = 32'h35dfb591;
    reset          = 1'b1;
    select_i       = 1'b0;
    start_i        = 1'b0;
    stop_i         = 1'b0;
    req_type_i     = 8'h00;
    req_request_i  = 8'h00;
    req_value_i    = 16'h0000;
    req_index_i    = 16'h0000;
    req_length_i   = 16'h00FF;
    m_tready_i     = 1'b0;
    cur_kind       = REQ_NONE;
    cur_idx        = 0;
    cur_len        = 0;
    rx_count       = 0;
    ack_count      = 0;
    expect_stream  = 1'b0;
    exp_addr       = '0;
    exp_conf       = '0;
    exp_configured = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    check_value(m_tvalid_o, 1'b0, "tvalid after reset");
    check_value(ack_o, 1'b0, "ack after reset");
    check_value(error_o, 1'b0, "error after reset");
    compare_registers();
    // Starts with select low must be ignored
    // Ready is high so a stray byte shows
    m_tready_i    = 1'b1;
    start_i       = 1'b1;
    req_type_i    = 8'h80;
    req_request_i = BREQ_GET_DESCRIPTOR;
    req_value_i   = {DTYPE_DEVICE, 8'h00};
    @(posedge clock);
    #1;
    req_type_i    = 8'h00;
    req_request_i = BREQ_SET_ADDRESS;
    req_value_i   = 16'h007F;
    @(posedge clock);
    #1;
    start_i = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    check_value(m_tvalid_o, 1'b0, "tvalid after unselected start");
    check_value(error_o, 1'b0, "error after unselected start");
    check_value(ack_count, 0, "ack pulses after unselected start");
    compare_registers();
    m_tready_i = 1'b0;
    get_descriptor(GET_DEV_DESC, 8'd0, 0);
    get_descriptor(GET_CONF_DESC, 8'd0, 0);
    for (int i = 0; i < 4; i++) begin
      get_descriptor(GET_STRING, 8'(i), 0);
    end
    // Index past the serial string falls back to the language list
    get_descriptor(GET_STRING, 8'd5, 0);
    get_descriptor(GET_DEV_DESC, 8'd0, 3);
    set_register(BREQ_SET_ADDRESS, 16'($random(seed)));
    set_register(BREQ_SET_CONFIG, 16'($random(seed)));
    // Vendor request and then standard bRequest 0
    send_unsupported(8'hC0, BREQ_GET_DESCRIPTOR);
    send_unsupported(8'h80, 8'h00);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- vlog.f
logic/usb_std_pkg.sv
logic/usb_desc_pkg.sv
logic/ep0_request_decoder.sv
logic/desc_streamer.sv
logic/device_state.sv
logic/ep0_status.sv
logic/ctl_pipe0_top.sv
tests/ctl_pipe0_tb.sv

//--- Bender.yml
package:
  name: ctl_pipe0

sources:
  - logic/usb_std_pkg.sv
  - logic/usb_desc_pkg.sv
  - logic/ep0_request_decoder.sv
  - logic/desc_streamer.sv
  - logic/device_state.sv
  - logic/ep0_status.sv
  - logic/ctl_pipe0_top.sv
  - target: test
    files:
      - tests/ctl_pipe0_tb.sv
